/* include/ads_i2c_settings.svh */
`ifndef ADS_I2C_SETTINGS_SVH
`define ADS_I2C_SETTINGS_SVH

// clk cycles per quarter of an scl bit, kept small for simulation
`define ADS_I2C_QUARTER_CYCLES 8

`define ADS_I2C_ADDR_W 7   // 7-bit device address
`define ADS_I2C_BYTE_W 8   // data byte and pointer
`define ADS_I2C_WORD_W 16  // register word

`endif

/* logic/ads_i2c_pkg.sv */
`default_nettype none

package ads_i2c_pkg;

    // host command kinds
    typedef enum logic [1:0] {
        cmd_set_pointer = 2'd0,
        cmd_write_reg   = 2'd1,
        cmd_read_reg    = 2'd2
    } cmd_kind_t;

    // single-bit bus operations run by the bit engine
    typedef enum logic [1:0] {
        op_start     = 2'd0,
        op_stop      = 2'd1,
        op_write_bit = 2'd2,
        op_read_bit  = 2'd3
    } bus_op_t;

endpackage

`default_nettype wire

/* logic/i2c_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ads_i2c_settings.svh"

module i2c_bit_engine (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 op_go,
    input  ads_i2c_pkg::bus_op_t      op,
    input  wire logic                 tx_bit,
    output logic                      op_done,
    output logic                      rx_bit,
    output logic                      scl_oe,
    output logic                      sda_oe,
    input  wire logic                 scl_in,
    input  wire logic                 sda_in
);

    localparam int unsigned QC = `ADS_I2C_QUARTER_CYCLES;
    localparam int unsigned CNT_W = $clog2(QC + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(QC - 1);

    logic                 busy;
    logic [1:0]           q;          // quarter index
    logic [CNT_W-1:0]     cnt;        // quarter divider
    ads_i2c_pkg::bus_op_t cur_op;
    logic                 cur_tx;

    logic                 advance;
    logic                 tick;
    logic                 load;
    ads_i2c_pkg::bus_op_t sel_op;
    logic [1:0]           sel_q;
    logic                 sel_tx;
    logic                 next_scl_oe;
    logic                 next_sda_oe;

    // third quarter stalls while scl is held low by the target
    assign advance = busy && ((q != 2'd2) || scl_in);
    assign tick    = advance && (cnt == LAST_CNT);
    assign load    = (!busy && op_go) || (tick && (q != 2'd3));

    // line pattern of the quarter about to start
    always_comb begin
        if (busy) begin
            sel_op = cur_op;
            sel_q  = q + 2'd1;
            sel_tx = cur_tx;
        end else begin
            sel_op = op;
            sel_q  = 2'd0;
            sel_tx = tx_bit;
        end
        next_scl_oe = (sel_q == 2'd0) || (sel_q == 2'd3);   // low, high, high, low
        next_sda_oe = 1'b0;
        case (sel_op)
            ads_i2c_pkg::op_start: begin
                next_scl_oe = (sel_q == 2'd3);
                next_sda_oe = (sel_q != 2'd0);   // sda falls with scl high
            end
            ads_i2c_pkg::op_stop: begin
                next_scl_oe = (sel_q == 2'd0);
                next_sda_oe = (sel_q != 2'd3);   // sda rises with scl high
            end
            ads_i2c_pkg::op_write_bit: begin
                next_sda_oe = ~sel_tx;
            end
            default: begin
                next_sda_oe = 1'b0;              // released for the target
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            q       <= 2'd0;
            cnt     <= '0;
            op_done <= 1'b0;
            scl_oe  <= 1'b0;
            sda_oe  <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (load) begin
                scl_oe <= next_scl_oe;
                sda_oe <= next_sda_oe;
            end
            if (!busy) begin
                if (op_go) begin
                    busy <= 1'b1;
                    q    <= 2'd0;
                    cnt  <= '0;
                end
            end else if (advance) begin
                if (tick) begin
                    cnt <= '0;
                    if (q == 2'd3) begin
                        busy    <= 1'b0;
                        op_done <= 1'b1;
                    end else begin
                        q <= q + 2'd1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && op_go) begin
            cur_op <= op;
            cur_tx <= tx_bit;
        end
        // cnt sits at 0 until scl is seen high in the third quarter
        if (busy && (q == 2'd2) && scl_in && (cnt == '0)) begin
            rx_bit <= sda_in;
        end
    end

    a_no_go_when_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        op_go |-> !busy
    );

    // data may only move under a high clock for start and stop
    a_sda_stable_scl_high : assert property (
        @(posedge clk) disable iff (!rst_n)
        (scl_in && $changed(sda_oe)) |->
            (cur_op == ads_i2c_pkg::op_start || cur_op == ads_i2c_pkg::op_stop)
    );

endmodule

`default_nettype wire

/* logic/i2c_transaction_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ads_i2c_settings.svh"

module i2c_transaction_seq (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cmd_req,
    input  ads_i2c_pkg::cmd_kind_t          cmd_kind,
    input  wire logic [`ADS_I2C_ADDR_W-1:0] cmd_dev_addr,
    input  wire logic [`ADS_I2C_BYTE_W-1:0] cmd_pointer,
    input  wire logic [`ADS_I2C_WORD_W-1:0] cmd_wdata,
    output logic                            cmd_ack,
    output logic [`ADS_I2C_WORD_W-1:0]      rd_data,
    output logic                            nack,
    output logic                            op_go,
    output ads_i2c_pkg::bus_op_t            op,
    output logic                            tx_bit,
    input  wire logic                       op_done,
    input  wire logic                       rx_bit
);

    localparam int unsigned BIT_CNT_W = $clog2(`ADS_I2C_BYTE_W);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(`ADS_I2C_BYTE_W - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_wr_bit,
        st_ack_in,
        st_rd_bit,
        st_ack_out,
        st_stop
    } seq_state_t;

    seq_state_t                  state;
    logic                        pending;     // op issued, op_done not yet seen
    logic [BIT_CNT_W-1:0]        bit_cnt;
    logic [1:0]                  byte_idx;
    ads_i2c_pkg::cmd_kind_t      kind_q;
    logic [`ADS_I2C_BYTE_W-1:0]  ptr_q;
    logic [`ADS_I2C_WORD_W-1:0]  wdata_q;
    logic [`ADS_I2C_BYTE_W-1:0]  tx_shift;
    logic [`ADS_I2C_WORD_W-1:0]  rd_shift;

    ads_i2c_pkg::bus_op_t        issue_op;
    logic                        issue_tx;
    logic [`ADS_I2C_BYTE_W-1:0]  next_wr_byte;
    logic                        last_wr_byte;

    always_comb begin
        issue_op = ads_i2c_pkg::op_read_bit;
        issue_tx = 1'b1;
        case (state)
            st_start:   issue_op = ads_i2c_pkg::op_start;
            st_stop:    issue_op = ads_i2c_pkg::op_stop;
            st_wr_bit: begin
                issue_op = ads_i2c_pkg::op_write_bit;
                issue_tx = tx_shift[`ADS_I2C_BYTE_W-1];   // msb first
            end
            st_ack_out: begin
                issue_op = ads_i2c_pkg::op_write_bit;
                issue_tx = (byte_idx == 2'd2);            // nack after last byte
            end
            default:    issue_op = ads_i2c_pkg::op_read_bit;
        endcase
    end

    // byte after the one just acked
    always_comb begin
        case (byte_idx)
            2'd0:    next_wr_byte = ptr_q;
            2'd1:    next_wr_byte = wdata_q[`ADS_I2C_WORD_W-1 -: `ADS_I2C_BYTE_W];
            default: next_wr_byte = wdata_q[`ADS_I2C_BYTE_W-1:0];
        endcase
    end

    assign last_wr_byte = (kind_q == ads_i2c_pkg::cmd_set_pointer && byte_idx == 2'd1) ||
                          (kind_q == ads_i2c_pkg::cmd_write_reg && byte_idx == 2'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            pending  <= 1'b0;
            op_go    <= 1'b0;
            cmd_ack  <= 1'b0;
            nack     <= 1'b0;
            rd_data  <= '0;
            bit_cnt  <= '0;
            byte_idx <= 2'd0;
        end else begin
            op_go <= 1'b0;
            if (state != st_idle && !pending) begin
                op_go   <= 1'b1;
                pending <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (cmd_ack && !cmd_req) begin
                        cmd_ack <= 1'b0;
                    end else if (!cmd_ack && cmd_req) begin
                        nack     <= 1'b0;
                        rd_data  <= '0;
                        bit_cnt  <= '0;
                        byte_idx <= 2'd0;
                        state    <= st_start;
                    end
                end
                st_start: begin
                    if (pending && op_done) begin
                        pending <= 1'b0;
                        state   <= st_wr_bit;
                    end
                end
                st_wr_bit: begin
                    if (pending && op_done) begin
                        pending <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            bit_cnt <= '0;
                            state   <= st_ack_in;
                        end
                    end
                end
                st_ack_in: begin
                    if (pending && op_done) begin
                        pending  <= 1'b0;
                        byte_idx <= byte_idx + 2'd1;
                        if (rx_bit) begin
                            nack  <= 1'b1;   // target did not answer
                            state <= st_stop;
                        end else if (kind_q == ads_i2c_pkg::cmd_read_reg) begin
                            state <= st_rd_bit;
                        end else if (last_wr_byte) begin
                            state <= st_stop;
                        end else begin
                            state <= st_wr_bit;
                        end
                    end
                end
                st_rd_bit: begin
                    if (pending && op_done) begin
                        pending <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            bit_cnt <= '0;
                            state   <= st_ack_out;
                        end
                    end
                end
                st_ack_out: begin
                    if (pending && op_done) begin
                        pending <= 1'b0;
                        if (byte_idx == 2'd2) begin
                            rd_data <= rd_shift;
                            state   <= st_stop;
                        end else begin
                            byte_idx <= 2'd2;
                            state    <= st_rd_bit;
                        end
                    end
                end
                st_stop: begin
                    if (pending && op_done) begin
                        pending <= 1'b0;
                        cmd_ack <= 1'b1;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state != st_idle && !pending) begin
            op     <= issue_op;
            tx_bit <= issue_tx;
        end
        if (state == st_idle && !cmd_ack && cmd_req) begin
            kind_q   <= cmd_kind;
            ptr_q    <= cmd_pointer;
            wdata_q  <= cmd_wdata;
            tx_shift <= {cmd_dev_addr, cmd_kind == ads_i2c_pkg::cmd_read_reg};
        end else if (pending && op_done) begin
            if (state == st_wr_bit) begin
                tx_shift <= {tx_shift[`ADS_I2C_BYTE_W-2:0], 1'b0};
            end else if (state == st_ack_in) begin
                tx_shift <= next_wr_byte;
            end else if (state == st_rd_bit) begin
                rd_shift <= {rd_shift[`ADS_I2C_WORD_W-2:0], rx_bit};
            end
        end
    end

    a_ack_after_bus_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> !pending && !op_go
    );

    a_ack_falls_after_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        (cmd_ack && !cmd_req) |=> !cmd_ack
    );

endmodule

`default_nettype wire

/* logic/ads_i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ads_i2c_settings.svh"

module ads_i2c_master (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cmd_req,
    input  ads_i2c_pkg::cmd_kind_t          cmd_kind,
    input  wire logic [`ADS_I2C_ADDR_W-1:0] cmd_dev_addr,
    input  wire logic [`ADS_I2C_BYTE_W-1:0] cmd_pointer,
    input  wire logic [`ADS_I2C_WORD_W-1:0] cmd_wdata,
    output logic                            cmd_ack,
    output logic [`ADS_I2C_WORD_W-1:0]      rd_data,
    output logic                            nack,
    output logic                            scl_oe,
    output logic                            sda_oe,
    input  wire logic                       scl_in,
    input  wire logic                       sda_in
);

    logic                 op_go;
    ads_i2c_pkg::bus_op_t op;
    logic                 tx_bit;
    logic                 op_done;
    logic                 rx_bit;

    i2c_transaction_seq i_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_kind     (cmd_kind),
        .cmd_dev_addr (cmd_dev_addr),
        .cmd_pointer  (cmd_pointer),
        .cmd_wdata    (cmd_wdata),
        .cmd_ack      (cmd_ack),
        .rd_data      (rd_data),
        .nack         (nack),
        .op_go        (op_go),
        .op           (op),
        .tx_bit       (tx_bit),
        .op_done      (op_done),
        .rx_bit       (rx_bit)
    );

    i2c_bit_engine i_bit_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .op_go   (op_go),
        .op      (op),
        .tx_bit  (tx_bit),
        .op_done (op_done),
        .rx_bit  (rx_bit),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .scl_in  (scl_in),
        .sda_in  (sda_in)
    );

endmodule

`default_nettype wire

/* testbench/ads_i2c_target_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ads_i2c_settings.svh"

module ads_i2c_target_model #(
    parameter logic [`ADS_I2C_ADDR_W-1:0] DEV_ADDR = 7'h48,
    parameter int unsigned MAX_STRETCH_Q = 3
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic scl,
    input  wire logic sda,
    output logic      scl_oe,
    output logic      sda_oe
);

    localparam int unsigned QC = `ADS_I2C_QUARTER_CYCLES;

    typedef enum logic [1:0] {ph_recv, ph_ack, ph_send, ph_mack} phase_t;

    logic [`ADS_I2C_WORD_W-1:0] regs [0:3];
    logic [1:0]                 ptr;
    logic                       prev_scl;
    logic                       prev_sda;
    logic                       listening;
    logic                       rw;
    logic                       second;       // low byte on the bus
    logic                       master_ack;
    phase_t                     phase;
    logic [3:0]                 bit_cnt;
    logic [2:0]                 byte_num;
    logic [7:0]                 shift;
    logic [7:0]                 hi_byte;
    logic [7:0]                 tx_byte;
    int unsigned                stretch_cnt;
    logic [31:0]                draw;
    integer                     seed = 32'hc4f9_6b51;

    assign scl_oe = (stretch_cnt != 0);

    // hold scl low for 0 to MAX_STRETCH_Q quarters after an ack slot
    task automatic hold_scl_low();
        draw = $random(seed);
        stretch_cnt <= (draw % (MAX_STRETCH_Q + 1)) * QC;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            regs[0]     <= 16'hC180;   // conversion, read only
            regs[1]     <= 16'h8583;
            regs[2]     <= 16'h8000;
            regs[3]     <= 16'h7FFF;
            ptr         <= 2'd0;
            prev_scl    <= 1'b1;
            prev_sda    <= 1'b1;
            listening   <= 1'b0;
            rw          <= 1'b0;
            second      <= 1'b0;
            master_ack  <= 1'b0;
            phase       <= ph_recv;
            bit_cnt     <= 4'd0;
            byte_num    <= 3'd0;
            shift       <= 8'd0;
            hi_byte     <= 8'd0;
            tx_byte     <= 8'd0;
            sda_oe      <= 1'b0;
            stretch_cnt <= 0;
        end else begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (stretch_cnt != 0) begin
                stretch_cnt <= stretch_cnt - 1;
            end
            if (prev_scl && scl && prev_sda && !sda) begin   // start
                listening <= 1'b1;
                phase     <= ph_recv;
                bit_cnt   <= 4'd0;
                byte_num  <= 3'd0;
                sda_oe    <= 1'b0;
            end else if (prev_scl && scl && !prev_sda && sda) begin   // stop
                listening <= 1'b0;
                sda_oe    <= 1'b0;
            end else if (listening && !prev_scl && scl) begin
                case (phase)
                    ph_recv: begin
                        shift   <= {shift[6:0], sda};
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    ph_send: bit_cnt <= bit_cnt + 4'd1;
                    ph_mack: master_ack <= !sda;
                    default: ;
                endcase
            end else if (listening && prev_scl && !scl) begin
                case (phase)
                    ph_recv: begin
                        if (bit_cnt == 4'd8) begin
                            bit_cnt  <= 4'd0;
                            byte_num <= byte_num + 3'd1;
                            if (byte_num == 3'd0) begin
                                if (shift[7:1] == DEV_ADDR) begin
                                    rw     <= shift[0];
                                    sda_oe <= 1'b1;
                                    phase  <= ph_ack;
                                end else begin
                                    listening <= 1'b0;   // not us, leave sda high
                                end
                            end else begin
                                sda_oe <= 1'b1;
                                phase  <= ph_ack;
                                if (byte_num == 3'd1) begin
                                    ptr <= shift[1:0];
                                end else if (byte_num == 3'd2) begin
                                    hi_byte <= shift;
                                end else if (byte_num == 3'd3 && ptr != 2'd0) begin
                                    regs[ptr] <= {hi_byte, shift};
                                end
                            end
                        end
                    end
                    ph_ack: begin
                        hold_scl_low();
                        if (rw) begin
                            tx_byte <= regs[ptr][15:8];
                            sda_oe  <= !regs[ptr][15];
                            second  <= 1'b0;
                            phase   <= ph_send;
                        end else begin
                            sda_oe <= 1'b0;
                            phase  <= ph_recv;
                        end
                    end
                    ph_send: begin
                        if (bit_cnt == 4'd8) begin
                            bit_cnt <= 4'd0;
                            sda_oe  <= 1'b0;
                            phase   <= ph_mack;
                        end else begin
                            sda_oe <= !tx_byte[3'd7 - bit_cnt[2:0]];
                        end
                    end
                    default: begin
                        hold_scl_low();
                        if (master_ack && !second) begin
                            tx_byte <= regs[ptr][7:0];
                            sda_oe  <= !regs[ptr][7];
                            second  <= 1'b1;
                            phase   <= ph_send;
                        end else begin
                            listening <= 1'b0;   // nack from the master, wait for stop
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_ads_i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ads_i2c_settings.svh"

module tb_ads_i2c_master;

    localparam int unsigned QC            = `ADS_I2C_QUARTER_CYCLES;
    localparam int unsigned MAX_STRETCH_Q = 3;
    localparam int unsigned HOLD_CYCLES   = 5;   // cmd_req kept high after ack

    logic                       clk;
    logic                       rst_n;
    logic                       cmd_req;
    ads_i2c_pkg::cmd_kind_t     cmd_kind;
    logic [`ADS_I2C_ADDR_W-1:0] cmd_dev_addr;
    logic [`ADS_I2C_BYTE_W-1:0] cmd_pointer;
    logic [`ADS_I2C_WORD_W-1:0] cmd_wdata;
    logic                       cmd_ack;
    logic [`ADS_I2C_WORD_W-1:0] rd_data;
    logic                       nack;
    logic                       scl_oe;
    logic                       sda_oe;
    logic                       tgt_scl_oe;
    logic                       tgt_sda_oe;
    logic                       scl;
    logic                       sda;

    string                      name_q[$];
    ads_i2c_pkg::cmd_kind_t     kind_q[$];
    logic [`ADS_I2C_ADDR_W-1:0] addr_q[$];
    logic [`ADS_I2C_BYTE_W-1:0] ptr_q[$];
    logic [`ADS_I2C_WORD_W-1:0] wdata_q[$];
    logic [`ADS_I2C_WORD_W-1:0] exp_rd_q[$];
    logic                       exp_nack_q[$];

    int unsigned cycle_count;
    int unsigned cycle_limit;
    int unsigned n_tests;
    int          idx;

    assign scl = !(scl_oe || tgt_scl_oe);   // wired-AND of both drivers
    assign sda = !(sda_oe || tgt_sda_oe);

    ads_i2c_master i_ads_i2c_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_kind     (cmd_kind),
        .cmd_dev_addr (cmd_dev_addr),
        .cmd_pointer  (cmd_pointer),
        .cmd_wdata    (cmd_wdata),
        .cmd_ack      (cmd_ack),
        .rd_data      (rd_data),
        .nack         (nack),
        .scl_oe       (scl_oe),
        .sda_oe       (sda_oe),
        .scl_in       (scl),
        .sda_in       (sda)
    );

    ads_i2c_target_model #(.MAX_STRETCH_Q(MAX_STRETCH_Q)) i_target (
        .clk    (clk),
        .rst_n  (rst_n),
        .scl    (scl),
        .sda    (sda),
        .scl_oe (tgt_scl_oe),
        .sda_oe (tgt_sda_oe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s %s: expected 0x%0h actual 0x%0h", test, what, expected, actual);
            abort_run("stopping at the first mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            abort_run("timeout, the DUT did not finish its commands in time");
        end
    end

    function automatic bit known_kind(input string word);
        return word == "set" || word == "write" || word == "read";
    endfunction

    function automatic ads_i2c_pkg::cmd_kind_t kind_of(input string word);
        if (word == "write") begin
            return ads_i2c_pkg::cmd_write_reg;
        end else if (word == "read") begin
            return ads_i2c_pkg::cmd_read_reg;
        end
        return ads_i2c_pkg::cmd_set_pointer;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          fields;
        string       line;
        string       t_name;
        string       t_kind;
        logic [31:0] t_addr;
        logic [31:0] t_ptr;
        logic [31:0] t_wdata;
        logic [31:0] t_rd;
        logic [31:0] t_nack;
        fd = $fopen("testbench/ads_i2c_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file testbench/ads_i2c_stim.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "#") begin   // skip column notes
                fields = $sscanf(line, "%s %s %h %h %h %h %h", t_name, t_kind,
                                 t_addr, t_ptr, t_wdata, t_rd, t_nack);
                if (fields == 7 && known_kind(t_kind)) begin
                    name_q.push_back(t_name);
                    kind_q.push_back(kind_of(t_kind));
                    addr_q.push_back(t_addr[`ADS_I2C_ADDR_W-1:0]);
                    ptr_q.push_back(t_ptr[`ADS_I2C_BYTE_W-1:0]);
                    wdata_q.push_back(t_wdata[`ADS_I2C_WORD_W-1:0]);
                    exp_rd_q.push_back(t_rd[`ADS_I2C_WORD_W-1:0]);
                    exp_nack_q.push_back(t_nack[0]);
                end else if (fields > 0) begin
                    abort_run("the stimulus file has a malformed line");
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_command(input int i);
        logic [`ADS_I2C_WORD_W-1:0] held;
        @(negedge clk);
        cmd_kind     = kind_q[i];
        cmd_dev_addr = addr_q[i];
        cmd_pointer  = ptr_q[i];
        cmd_wdata    = wdata_q[i];
        cmd_req      = 1'b1;
        @(negedge clk);
        while (!cmd_ack) begin
            @(negedge clk);
        end
        check_value(name_q[i], "rd_data", 32'(exp_rd_q[i]), 32'(rd_data));
        check_value(name_q[i], "nack", 32'(exp_nack_q[i]), 32'(nack));
        check_value(name_q[i], "scl_oe", 32'd0, 32'(scl_oe));
        check_value(name_q[i], "sda_oe", 32'd0, 32'(sda_oe));
        check_value(name_q[i], "scl line", 32'd1, 32'(scl));
        check_value(name_q[i], "sda line", 32'd1, 32'(sda));
        held = rd_data;
        repeat (HOLD_CYCLES) begin   // back-pressure keeps ack up and the bus idle
            @(negedge clk);
            check_value(name_q[i], "cmd_ack held", 32'd1, 32'(cmd_ack));
            check_value(name_q[i], "rd_data held", 32'(held), 32'(rd_data));
            check_value(name_q[i], "scl_oe idle", 32'd0, 32'(scl_oe));
            check_value(name_q[i], "sda_oe idle", 32'd0, 32'(sda_oe));
        end
        cmd_req = 1'b0;
        @(negedge clk);
        check_value(name_q[i], "cmd_ack fall", 32'd0, 32'(cmd_ack));
        check_value(name_q[i], "rd_data after ack", 32'(held), 32'(rd_data));
    endtask

    initial begin
        rst_n        = 1'b0;
        cmd_req      = 1'b0;
        cmd_kind     = ads_i2c_pkg::cmd_set_pointer;
        cmd_dev_addr = '0;
        cmd_pointer  = '0;
        cmd_wdata    = '0;
        load_stimulus();
        n_tests = name_q.size();
        if (n_tests == 0) begin
            abort_run("the stimulus file holds no commands");
        end
        cycle_limit = n_tests * 40 * 4 * (QC + MAX_STRETCH_Q * QC)
                      + n_tests * (HOLD_CYCLES + 4) + 16;
        repeat (3) @(negedge clk);
        check_value("reset", "scl_oe", 32'd0, 32'(scl_oe));
        check_value("reset", "sda_oe", 32'd0, 32'(sda_oe));
        check_value("reset", "cmd_ack", 32'd0, 32'(cmd_ack));
        check_value("reset", "nack", 32'd0, 32'(nack));
        check_value("reset", "rd_data", 32'd0, 32'(rd_data));
        rst_n = 1'b1;
        for (idx = 0; idx < int'(n_tests); idx++) begin
            run_command(idx);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* ads_i2c_master.f */
+incdir+include
logic/ads_i2c_pkg.sv
logic/i2c_bit_engine.sv
logic/i2c_transaction_seq.sv
logic/ads_i2c_master.sv
testbench/ads_i2c_target_model.sv
testbench/tb_ads_i2c_master.sv

/* Makefile */
# Verilator flow for the ADS1115 I2C controller

VERILATOR ?= verilator
TB_TOP    ?= tb_ads_i2c_master
RTL_TOP   ?= ads_i2c_master
FILELIST  ?= ads_i2c_master.f
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(SIM_LOG)
	@if grep -q "$(PASS_TEXT)" $(SIM_LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(SIM_LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* testbench/ads_i2c_stim.txt */
# name kind dev_addr pointer wdata exp_rd_data exp_nack
# kind is set, write or read; the other columns are hex
rd_conv_reset   read  48 00 0000 c180 0
set_ptr_cfg     set   48 01 0000 0000 0
rd_cfg_reset    read  48 01 0000 8583 0
wr_cfg          write 48 01 4a23 0000 0
rd_cfg          read  48 01 0000 4a23 0
wr_lo_thresh    write 48 02 1234 0000 0
rd_lo_thresh    read  48 02 0000 1234 0
set_ptr_hi      set   48 03 0000 0000 0
rd_hi_reset     read  48 03 0000 7fff 0
wr_hi_thresh    write 48 03 a5c3 0000 0
wr_conv         write 48 00 5555 0000 0
rd_conv         read  48 00 0000 c180 0
wrong_addr_wr   write 49 01 ffff 0000 1
wrong_addr_rd   read  20 00 0000 0000 1
set_ptr_hi_2    set   48 03 0000 0000 0
rd_hi_thresh    read  48 03 0000 a5c3 0
